/* hdl/vc_router_pkg.sv */
// Virtual channel router definitions
`default_nettype none

package vc_router_pkg;

  // ==============================
  // port directions
  // ==============================

  // output direction carried in every flit header
  // values double as port indices on all router buses
  typedef enum logic [2:0] {
    DirNorth = 3'd0,
    DirEast  = 3'd1,
    DirSouth = 3'd2,
    DirWest  = 3'd3,
    DirLocal = 3'd4
  } route_dir_e;

  // number of physical ports, one per direction
  localparam int NumDirs = int'(DirLocal) + 1;

  // width of the direction field inside a flit
  localparam int DirWidth = $bits(route_dir_e);

  // ==============================
  // flit layout
  // ==============================

  // payload occupies bits [DataWidth-1:0]
  // direction field starts DirOffset bits above the payload
  // i.e. flit[DataWidth+DirOffset +: DirWidth]
  localparam int DirOffset = 0;

  // total flit width for a given payload width
  // look-ahead routing, so no further header fields
  function automatic int flit_width(input int data_width);
    return data_width + DirOffset + DirWidth;
  endfunction

endpackage

`default_nettype wire

/* hdl/vc_input_port.sv */
// Router input port
`timescale 1ns/1ps
`default_nettype none

module vc_input_port import vc_router_pkg::*; #(
  parameter  int NumVC      = 2,
  parameter  int VCDepth    = 2,
  parameter  int DataWidth  = 16,
  localparam int NumVCWidth = (NumVC > 1) ? $clog2(NumVC) : 1,
  localparam int FlitWidth  = flit_width(DataWidth)
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  // upstream link
  input  logic       [NumVC-1:0]                 data_v_i,
  input  logic       [FlitWidth-1:0]             data_i,
  output logic                                   credit_v_o,
  output logic       [NumVCWidth-1:0]            credit_id_o,
  // head flit of every VC
  output logic       [NumVC-1:0]                 head_v_o,
  output route_dir_e [NumVC-1:0]                 head_dir_o,
  output logic       [NumVC-1:0][DataWidth-1:0]  head_data_o,
  // pop request from switch allocation
  input  logic                                   pop_i,
  input  logic       [NumVCWidth-1:0]            pop_vc_i
);

  localparam int PtrWidth = (VCDepth > 1) ? $clog2(VCDepth) : 1;
  localparam int CntWidth = $clog2(VCDepth + 1);

  // one credit goes back upstream per popped flit
  // same cycle as the grant
  assign credit_v_o  = pop_i;
  assign credit_id_o = pop_vc_i;

  // ==============================
  // per VC circular FIFO
  // ==============================

  for (genvar v = 0; v < NumVC; v++) begin : gen_vc
    logic                 push;
    logic                 pop;
    logic [PtrWidth-1:0]  wr_ptr_q;
    logic [PtrWidth-1:0]  rd_ptr_q;
    logic [CntWidth-1:0]  count_q;
    logic [FlitWidth-1:0] mem_q [VCDepth];
    logic [FlitWidth-1:0] head_flit;

    // upstream valid is one-hot over the VCs
    assign push = data_v_i[v];
    assign pop  = pop_i && (pop_vc_i == NumVCWidth'(v));

    // pointers wrap at VCDepth, not necessarily a power of two
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PtrWidth'(VCDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PtrWidth'(VCDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        if (push && !pop) begin
          count_q <= count_q + 1'b1;
        end else if (pop && !push) begin
          count_q <= count_q - 1'b1;
        end
      end
    end

    // storage
    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= data_i;
      end
    end

    // head is visible the cycle after the write edge
    assign head_flit      = mem_q[rd_ptr_q];
    assign head_v_o[v]    = (count_q != '0);
    assign head_dir_o[v]  = route_dir_e'(head_flit[DataWidth+DirOffset +: DirWidth]);
    assign head_data_o[v] = head_flit[DataWidth-1:0];

    // upstream must hold a credit before it sends
    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
      push |-> (count_q != CntWidth'(VCDepth)))
      else $error("push into full VC %0d", v);

    // allocation only grants VCs with a head flit
    a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
      pop |-> (count_q != '0))
      else $error("pop of empty VC %0d", v);
  end

endmodule

`default_nettype wire

/* hdl/vc_sa_local.sv */
// Local switch allocator
`timescale 1ns/1ps
`default_nettype none

module vc_sa_local import vc_router_pkg::*; #(
  parameter  int NumVC      = 2,
  localparam int NumVCWidth = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic       [NumVC-1:0]      head_v_i,
  input  route_dir_e [NumVC-1:0]      head_dir_i,
  input  logic       [NumDirs-1:0]    out_has_credit_i,
  input  logic                        grant_i,
  output logic       [NumDirs-1:0]    req_dir_oh_o,
  output logic       [NumVCWidth-1:0] req_vc_o
);

  logic [NumVC-1:0]      eligible;
  logic [NumVCWidth-1:0] rr_ptr_q;
  logic                  found;

  // a VC competes only if its target output has a free VC
  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      eligible[v] = head_v_i[v] && out_has_credit_i[head_dir_i[v]];
    end
  end

  // search upward from the pointer, wrapping around
  always_comb begin
    int unsigned idx;
    found    = 1'b0;
    req_vc_o = '0;
    for (int i = 0; i < NumVC; i++) begin
      idx = (int'(rr_ptr_q) + i) % NumVC;
      if (!found && eligible[idx]) begin
        found    = 1'b1;
        req_vc_o = NumVCWidth'(idx);
      end
    end
  end

  // request goes to the winner's output only
  always_comb begin
    req_dir_oh_o = '0;
    if (found) begin
      req_dir_oh_o[head_dir_i[req_vc_o]] = 1'b1;
    end
  end

  // pointer moves past the winner once it wins globally
  // a losing VC keeps its priority
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q <= '0;
    end else if (grant_i) begin
      rr_ptr_q <= (req_vc_o == NumVCWidth'(NumVC - 1)) ? '0 : req_vc_o + 1'b1;
    end
  end

  a_req_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(req_dir_oh_o))
    else $error("local SA request not one-hot");

  // global SA must not grant an input that made no request
  a_grant_has_req: assert property (@(posedge clk_i) disable iff (reset_i)
    grant_i |-> found)
    else $error("grant without local request");

endmodule

`default_nettype wire

/* hdl/vc_sa_global.sv */
// Global switch allocator
`timescale 1ns/1ps
`default_nettype none

module vc_sa_global import vc_router_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [NumDirs-1:0] req_i,
  output logic [NumDirs-1:0] grant_o
);

  localparam int PtrWidth = $clog2(NumDirs);

  logic [PtrWidth-1:0] rr_ptr_q;
  logic [PtrWidth-1:0] winner;
  logic [NumDirs-1:0]  prio_mask;
  logic [NumDirs-1:0]  req_hi;

  // ==============================
  // masked priority arbiter
  // ==============================

  // inputs at or above the pointer have priority
  always_comb begin
    for (int i = 0; i < NumDirs; i++) begin
      prio_mask[i] = (i >= int'(rr_ptr_q));
    end
  end

  assign req_hi = req_i & prio_mask;

  // lowest request overall
  // lowest masked request overrides it
  always_comb begin
    winner = '0;
    for (int i = NumDirs - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        winner = PtrWidth'(i);
      end
    end
    for (int i = NumDirs - 1; i >= 0; i--) begin
      if (req_hi[i]) begin
        winner = PtrWidth'(i);
      end
    end
  end

  always_comb begin
    grant_o = '0;
    if (|req_i) begin
      grant_o[winner] = 1'b1;
    end
  end

  // pointer moves past the winner on every grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q <= '0;
    end else if (|req_i) begin
      rr_ptr_q <= (winner == PtrWidth'(NumDirs - 1)) ? '0 : winner + 1'b1;
    end
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grant_o))
    else $error("global SA grant not one-hot");

endmodule

`default_nettype wire

/* hdl/vc_out_credits.sv */
// Output credit counters
`timescale 1ns/1ps
`default_nettype none

module vc_out_credits #(
  parameter  int NumVC      = 2,
  parameter  int VCDepth    = 2,
  localparam int NumVCWidth = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // credit return from downstream
  input  logic                  credit_v_i,
  input  logic [NumVCWidth-1:0] credit_id_i,
  // a flit was granted to this output
  input  logic                  consume_i,
  // VC selection towards the allocators and the switch
  output logic                  has_credit_o,
  output logic [NumVCWidth-1:0] sel_vc_o
);

  localparam int CntWidth = $clog2(VCDepth + 1);

  logic [NumVC-1:0] cnt_nz;

  // ==============================
  // per VC counters
  // ==============================

  for (genvar v = 0; v < NumVC; v++) begin : gen_cnt
    logic                inc;
    logic                dec;
    logic [CntWidth-1:0] cnt_q;

    assign inc = credit_v_i && (credit_id_i == NumVCWidth'(v));
    assign dec = consume_i && (sel_vc_o == NumVCWidth'(v));

    // starts full, downstream buffers are empty after reset
    // credit in and grant in the same cycle cancel out
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        cnt_q <= CntWidth'(VCDepth);
      end else if (inc && !dec) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (dec && !inc) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    assign cnt_nz[v] = (cnt_q != '0);

    // downstream never returns more than it was sent
    a_cnt_max: assert property (@(posedge clk_i) disable iff (reset_i)
      (inc && !dec) |-> (cnt_q < VCDepth))
      else $error("credit counter of VC %0d above depth", v);
  end

  // ==============================
  // lowest free VC
  // ==============================

  always_comb begin
    sel_vc_o = '0;
    for (int v = NumVC - 1; v >= 0; v--) begin
      if (cnt_nz[v]) begin
        sel_vc_o = NumVCWidth'(v);
      end
    end
  end

  assign has_credit_o = |cnt_nz;

  // the local SA masks outputs with no credit
  a_consume_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    consume_i |-> has_credit_o)
    else $error("grant to output without credit");

endmodule

`default_nettype wire

/* hdl/vc_switch_traversal.sv */
// Crossbar and output register
`timescale 1ns/1ps
`default_nettype none

module vc_switch_traversal import vc_router_pkg::*; #(
  parameter  int NumVC      = 2,
  parameter  int DataWidth  = 16,
  localparam int NumVCWidth = (NumVC > 1) ? $clog2(NumVC) : 1,
  localparam int FlitWidth  = flit_width(DataWidth)
) (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  route_dir_e [NumDirs-1:0][NumVC-1:0]          head_dir_i,
  input  logic       [NumDirs-1:0][NumVC-1:0][DataWidth-1:0] head_data_i,
  // grant_i[output][input]
  input  logic       [NumDirs-1:0][NumDirs-1:0]        grant_i,
  // winning VC per input, chosen VC per output
  input  logic       [NumDirs-1:0][NumVCWidth-1:0]     in_vc_i,
  input  logic       [NumDirs-1:0][NumVCWidth-1:0]     out_vc_i,
  output logic       [NumDirs-1:0][NumVC-1:0]          data_v_o,
  output logic       [NumDirs-1:0][FlitWidth-1:0]      data_o
);

  for (genvar o = 0; o < NumDirs; o++) begin : gen_out
    logic                 any_grant;
    logic [FlitWidth-1:0] flit_mux;
    logic [NumVC-1:0]     data_v_q;
    logic [FlitWidth-1:0] data_q;

    assign any_grant = |grant_i[o];

    // and-or mux, at most one grant per output
    // direction field is kept, only the VC changes
    always_comb begin
      flit_mux = '0;
      for (int i = 0; i < NumDirs; i++) begin
        if (grant_i[o][i]) begin
          flit_mux[DataWidth+DirOffset +: DirWidth] = head_dir_i[i][in_vc_i[i]];
          flit_mux[DataWidth-1:0]                   = head_data_i[i][in_vc_i[i]];
        end
      end
    end

    // valid carries the output VC one-hot
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        data_v_q <= '0;
      end else if (any_grant) begin
        data_v_q <= NumVC'(1) << out_vc_i[o];
      end else begin
        data_v_q <= '0;
      end
    end

    always_ff @(posedge clk_i) begin
      if (any_grant) begin
        data_q <= flit_mux;
      end
    end

    assign data_v_o[o] = data_v_q;
    assign data_o[o]   = data_q;

    // flit must leave on the port its header names
    a_dir_match: assert property (@(posedge clk_i) disable iff (reset_i)
      (data_v_q != '0) |-> (data_q[DataWidth+DirOffset +: DirWidth] == DirWidth'(o)))
      else $error("flit on output %0d carries wrong direction", o);
  end

endmodule

`default_nettype wire

/* hdl/vc_router.sv */
// Virtual channel router top
`timescale 1ns/1ps
`default_nettype none

module vc_router import vc_router_pkg::*; #(
  parameter  int NumVC      = 2,
  parameter  int VCDepth    = 2,
  parameter  int DataWidth  = 16,
  localparam int NumVCWidth = (NumVC > 1) ? $clog2(NumVC) : 1,
  localparam int FlitWidth  = flit_width(DataWidth)
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  // upstream links, one per input
  input  logic [NumDirs-1:0][NumVC-1:0]       data_v_i,
  input  logic [NumDirs-1:0][FlitWidth-1:0]   data_i,
  output logic [NumDirs-1:0]                  credit_v_o,
  output logic [NumDirs-1:0][NumVCWidth-1:0]  credit_id_o,
  // downstream links, one per output
  output logic [NumDirs-1:0][NumVC-1:0]       data_v_o,
  output logic [NumDirs-1:0][FlitWidth-1:0]   data_o,
  input  logic [NumDirs-1:0]                  credit_v_i,
  input  logic [NumDirs-1:0][NumVCWidth-1:0]  credit_id_i
);

  // head flits per input and VC
  logic       [NumDirs-1:0][NumVC-1:0]                head_v;
  route_dir_e [NumDirs-1:0][NumVC-1:0]                head_dir;
  logic       [NumDirs-1:0][NumVC-1:0][DataWidth-1:0] head_data;
  // local SA result, indexed by input
  logic       [NumDirs-1:0][NumDirs-1:0]              req_dir_oh;
  logic       [NumDirs-1:0][NumVCWidth-1:0]           req_vc;
  // global SA, indexed [output][input]
  logic       [NumDirs-1:0][NumDirs-1:0]              sa_req;
  logic       [NumDirs-1:0][NumDirs-1:0]              sa_grant;
  logic       [NumDirs-1:0]                           in_grant;
  // credit state per output
  logic       [NumDirs-1:0]                           out_has_credit;
  logic       [NumDirs-1:0][NumVCWidth-1:0]           out_vc;
  logic       [NumDirs-1:0]                           consume;

  // ==============================
  // input side
  // ==============================

  for (genvar i = 0; i < NumDirs; i++) begin : gen_in
    vc_input_port #(
      .NumVC     (NumVC),
      .VCDepth   (VCDepth),
      .DataWidth (DataWidth)
    ) i_input_port (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .data_v_i    (data_v_i[i]),
      .data_i      (data_i[i]),
      .credit_v_o  (credit_v_o[i]),
      .credit_id_o (credit_id_o[i]),
      .head_v_o    (head_v[i]),
      .head_dir_o  (head_dir[i]),
      .head_data_o (head_data[i]),
      .pop_i       (in_grant[i]),
      .pop_vc_i    (req_vc[i])
    );

    vc_sa_local #(
      .NumVC (NumVC)
    ) i_sa_local (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .head_v_i         (head_v[i]),
      .head_dir_i       (head_dir[i]),
      .out_has_credit_i (out_has_credit),
      .grant_i          (in_grant[i]),
      .req_dir_oh_o     (req_dir_oh[i]),
      .req_vc_o         (req_vc[i])
    );
  end

  // turn input-side requests into per-output columns
  // each input is granted by at most one output
  always_comb begin
    in_grant = '0;
    for (int o = 0; o < NumDirs; o++) begin
      for (int i = 0; i < NumDirs; i++) begin
        sa_req[o][i] = req_dir_oh[i][o];
        in_grant[i] |= sa_grant[o][i];
      end
    end
  end

  // ==============================
  // output side
  // ==============================

  for (genvar o = 0; o < NumDirs; o++) begin : gen_out
    vc_sa_global i_sa_global (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (sa_req[o]),
      .grant_o (sa_grant[o])
    );

    // any grant here takes one downstream slot
    assign consume[o] = |sa_grant[o];

    vc_out_credits #(
      .NumVC   (NumVC),
      .VCDepth (VCDepth)
    ) i_out_credits (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .credit_v_i   (credit_v_i[o]),
      .credit_id_i  (credit_id_i[o]),
      .consume_i    (consume[o]),
      .has_credit_o (out_has_credit[o]),
      .sel_vc_o     (out_vc[o])
    );
  end

  // switch traversal, registered outputs
  vc_switch_traversal #(
    .NumVC     (NumVC),
    .DataWidth (DataWidth)
  ) i_switch_traversal (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .head_dir_i  (head_dir),
    .head_data_i (head_data),
    .grant_i     (sa_grant),
    .in_vc_i     (req_vc),
    .out_vc_i    (out_vc),
    .data_v_o    (data_v_o),
    .data_o      (data_o)
  );

endmodule

`default_nettype wire

/* dv/vc_router_tb.sv */
// Router testbench
`timescale 1ns/1ps
`default_nettype none

module vc_router_tb import vc_router_pkg::*; ();

  localparam int NumVC        = 2;
  localparam int VCDepth      = 2;
  localparam int DataWidth    = 16;
  localparam int NumVCWidth   = (NumVC > 1) ? $clog2(NumVC) : 1;
  localparam int FlitWidth    = flit_width(DataWidth);
  localparam int ClkPeriod    = 40;
  localparam int ResetCycles  = 16;
  localparam int Seed         = 95912;
  localparam int MaxVec       = 64;
  localparam int VecFields    = 6;
  localparam int NoPort       = 7;
  localparam int StimTimeout  = 2000;
  localparam int DrainTimeout = 500;
  localparam int QuietCycles  = 8;

  // one injected flit as the scoreboard sees it
  typedef struct packed {
    logic [2:0]           port;
    logic [3:0]           vc;
    route_dir_e           dir;
    logic [DataWidth-1:0] payload;
    logic                 lone;
    logic [31:0]          sent;
  } flit_rec_t;

  // a downstream credit waiting to go back
  typedef struct packed {
    logic [2:0]  out;
    logic [3:0]  vc;
    logic [31:0] due;
  } credit_rec_t;

  logic                               clk;
  logic                               reset;
  logic [NumDirs-1:0][NumVC-1:0]      up_data_v;
  logic [NumDirs-1:0][FlitWidth-1:0]  up_data;
  logic [NumDirs-1:0]                 up_credit_v;
  logic [NumDirs-1:0][NumVCWidth-1:0] up_credit_id;
  logic [NumDirs-1:0][NumVC-1:0]      dn_data_v;
  logic [NumDirs-1:0][FlitWidth-1:0]  dn_data;
  logic [NumDirs-1:0]                 dn_credit_v;
  logic [NumDirs-1:0][NumVCWidth-1:0] dn_credit_id;

  // vector words with six per line
  logic [15:0]        vec_mem [VecFields*MaxVec];
  int                 n_vec;
  int                 vec_next;
  int                 pend_q[$];
  flit_rec_t          sb_q[$];
  credit_rec_t        ret_q[$];
  // credit models of the upstream and downstream side
  int                 up_credit [NumDirs][NumVC];
  int                 ds_credit [NumDirs][NumVC];
  logic [NumDirs-1:0] up_ret_v;
  int                 up_ret_id [NumDirs];
  logic [NumDirs-1:0] ds_ret_v;
  int                 ds_ret_id [NumDirs];
  logic [NumDirs-1:0] stall_mask;
  int                 cyc;
  int                 inj_cnt;
  int                 deliv_cnt;
  int                 cred_cnt;
  int                 value_errs;
  int                 order_errs;
  int                 proto_errs;
  int                 timeouts;

  vc_router #(
    .NumVC     (NumVC),
    .VCDepth   (VCDepth),
    .DataWidth (DataWidth)
  ) dut_i (
    .clk_i       (clk),
    .reset_i     (reset),
    .data_v_i    (up_data_v),
    .data_i      (up_data),
    .credit_v_o  (up_credit_v),
    .credit_id_o (up_credit_id),
    .data_v_o    (dn_data_v),
    .data_o      (dn_data),
    .credit_v_i  (dn_credit_v),
    .credit_id_i (dn_credit_id)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic int vec_field(input int idx, input int f);
    return int'(vec_mem[idx * VecFields + f]);
  endfunction

  // lowest downstream VC the model still holds a credit for
  // returns -1 when every VC is empty
  function automatic int lowest_free_vc(input int o);
    int sel;
    sel = -1;
    for (int v = NumVC - 1; v >= 0; v--) begin
      if (ds_credit[o][v] > 0) begin
        sel = v;
      end
    end
    return sel;
  endfunction

  // ==============================
  // output side checks
  // ==============================

  task automatic check_outputs();
    int                   vc;
    int                   exp_vc;
    int                   hit;
    int                   older;
    logic [DataWidth-1:0] payload;
    for (int o = 0; o < NumDirs; o++) begin
      if (inj_cnt == 0) begin
        assert (dn_data_v[o] == '0) else begin
          proto_errs++;
          $display("output %0d went valid before any flit was injected", o);
        end
      end
      if (dn_data_v[o] != '0) begin
        assert ($onehot(dn_data_v[o])) else begin
          proto_errs++;
          $display("output %0d valid is not one-hot: %b", o, dn_data_v[o]);
        end
        deliv_cnt++;
        vc = -1;
        for (int v = NumVC - 1; v >= 0; v--) begin
          if (dn_data_v[o][v]) begin
            vc = v;
          end
        end
        exp_vc = lowest_free_vc(o);
        assert (exp_vc >= 0) else begin
          proto_errs++;
          $display("output %0d sent a flit with no downstream credit left", o);
        end
        assert (vc == exp_vc) else begin
          value_errs++;
          $display("[FAIL] test=lowest_free_vc out=%0d expected=%0d actual=%0d", o, exp_vc, vc);
        end
        if (ds_credit[o][vc] > 0) begin
          ds_credit[o][vc]--;
        end
        // downstream consumes the flit after a random delay
        ret_q.push_back('{out: 3'(o), vc: 4'(vc), due: 32'(cyc + 1 + int'($urandom % 4))});
        assert (int'(dn_data[o][DataWidth+DirOffset +: DirWidth]) == o) else begin
          value_errs++;
          $display("[FAIL] test=dir_field expected=%0d actual=%0d", o,
                   dn_data[o][DataWidth+DirOffset +: DirWidth]);
        end
        payload = dn_data[o][DataWidth-1:0];
        hit = -1;
        for (int k = 0; k < sb_q.size(); k++) begin
          if (hit < 0 && int'(sb_q[k].dir) == o && sb_q[k].payload == payload) begin
            hit = k;
          end
        end
        assert (hit >= 0) else begin
          proto_errs++;
          $display("output %0d delivered a flit that was never sent or came twice: %h",
                   o, payload);
        end
        if (hit >= 0) begin
          // an older flit of the same input VC and output must not be left behind
          older = -1;
          for (int k = 0; k < hit; k++) begin
            if (older < 0 && sb_q[k].port == sb_q[hit].port && sb_q[k].vc == sb_q[hit].vc
                && sb_q[k].dir == sb_q[hit].dir) begin
              older = k;
            end
          end
          assert (older < 0) else begin
            order_errs++;
            $display("[FAIL] test=inject_order expected=%h actual=%h",
                     sb_q[older].payload, payload);
          end
          if (sb_q[hit].lone) begin
            assert (cyc == int'(sb_q[hit].sent) + 2) else begin
              value_errs++;
              $display("[FAIL] test=lone_latency expected=%0d actual=%0d",
                       int'(sb_q[hit].sent) + 2, cyc);
            end
          end
          sb_q.delete(hit);
        end
      end
    end
    // credits back to the upstream model
    // applied only after this cycle's sends
    for (int p = 0; p < NumDirs; p++) begin
      up_ret_v[p]  = up_credit_v[p];
      up_ret_id[p] = int'(up_credit_id[p]);
      if (inj_cnt == 0) begin
        assert (!up_credit_v[p]) else begin
          proto_errs++;
          $display("input %0d returned a credit before any flit was injected", p);
        end
      end else if (up_credit_v[p]) begin
        assert (up_credit[p][up_ret_id[p]] < VCDepth) else begin
          proto_errs++;
          $display("input %0d returned a credit for VC %0d with no flit outstanding",
                   p, up_ret_id[p]);
        end
        cred_cnt++;
      end
    end
  endtask

  // ==============================
  // downstream credit model
  // ==============================

  task automatic return_ds_credits();
    int  del_idx;
    // credits driven last cycle are counted by the router from now on
    for (int o = 0; o < NumDirs; o++) begin
      if (ds_ret_v[o]) begin
        ds_credit[o][ds_ret_id[o]]++;
      end
    end
    dn_credit_v  = '0;
    dn_credit_id = '0;
    ds_ret_v     = '0;
    // at most one credit per output and cycle
    // stalled outputs return none
    for (int o = 0; o < NumDirs; o++) begin
      del_idx = -1;
      for (int k = 0; k < ret_q.size(); k++) begin
        if (del_idx < 0 && !stall_mask[o] && int'(ret_q[k].out) == o
            && int'(ret_q[k].due) <= cyc) begin
          del_idx = k;
        end
      end
      if (del_idx >= 0) begin
        dn_credit_v[o]  = 1'b1;
        dn_credit_id[o] = NumVCWidth'(ret_q[del_idx].vc);
        ds_ret_v[o]     = 1'b1;
        ds_ret_id[o]    = int'(ret_q[del_idx].vc);
        ret_q.delete(del_idx);
      end
    end
  endtask

  // ==============================
  // upstream injection
  // ==============================

  task automatic drive_injections();
    logic [NumDirs-1:0] port_blocked;
    int                 sent_now;
    int                 idx;
    int                 p;
    int                 v;
    int                 dir;
    logic               was_idle;
    port_blocked = '0;
    sent_now     = 0;
    was_idle     = (sb_q.size() == 0);
    up_data_v    = '0;
    // lines whose cycle has come join the pending list
    while (vec_next < n_vec && vec_field(vec_next, 0) <= cyc) begin
      stall_mask = vec_mem[vec_next * VecFields + 5][NumDirs-1:0];
      if (vec_field(vec_next, 1) != NoPort) begin
        pend_q.push_back(vec_next);
      end
      vec_next++;
    end
    idx = 0;
    while (idx < pend_q.size()) begin
      p   = vec_field(pend_q[idx], 1);
      v   = vec_field(pend_q[idx], 2);
      dir = vec_field(pend_q[idx], 3);
      // one flit per port and cycle
      // later lines of a held port wait too
      if (port_blocked[p] || up_credit[p][v] == 0) begin
        port_blocked[p] = 1'b1;
        idx++;
      end else begin
        port_blocked[p] = 1'b1;
        up_data_v[p][v] = 1'b1;
        up_data[p]      = '0;
        up_data[p][DataWidth+DirOffset +: DirWidth] = DirWidth'(dir);
        up_data[p][DataWidth-1:0] = DataWidth'(vec_field(pend_q[idx], 4));
        up_credit[p][v]--;
        sb_q.push_back('{port: 3'(p), vc: 4'(v), dir: route_dir_e'(dir),
                         payload: DataWidth'(vec_field(pend_q[idx], 4)),
                         lone: 1'b0, sent: 32'(cyc)});
        pend_q.delete(idx);
        sent_now++;
        inj_cnt++;
      end
    end
    // lone flit into an idle router with credit at its output
    if (was_idle && sent_now == 1 && lowest_free_vc(int'(sb_q[0].dir)) >= 0) begin
      sb_q[0].lone = 1'b1;
    end
    for (int q = 0; q < NumDirs; q++) begin
      if (up_ret_v[q]) begin
        up_credit[q][up_ret_id[q]]++;
      end
    end
  endtask

  task automatic run_cycle();
    @(negedge clk);
    check_outputs();
    return_ds_credits();
    drive_injections();
    cyc++;
  endtask

  initial begin
    int seed_draw;
    int waited;
    seed_draw    = $urandom(Seed);
    reset        = 1'b1;
    up_data_v    = '0;
    up_data      = '0;
    dn_credit_v  = '0;
    dn_credit_id = '0;
    up_ret_v     = '0;
    ds_ret_v     = '0;
    stall_mask   = '0;
    cyc          = 0;
    inj_cnt      = 0;
    deliv_cnt    = 0;
    cred_cnt     = 0;
    value_errs   = 0;
    order_errs   = 0;
    proto_errs   = 0;
    timeouts     = 0;
    vec_next     = 0;
    for (int p = 0; p < NumDirs; p++) begin
      up_ret_id[p] = 0;
      ds_ret_id[p] = 0;
      for (int v = 0; v < NumVC; v++) begin
        up_credit[p][v] = VCDepth;
        ds_credit[p][v] = VCDepth;
      end
    end
    $readmemh("dv/vc_router_vectors.txt", vec_mem);
    n_vec = 0;
    while (n_vec < MaxVec && vec_mem[n_vec * VecFields] !== 16'hffff
           && !$isunknown(vec_mem[n_vec * VecFields])) begin
      n_vec++;
    end
    assert (n_vec > 0) else begin
      proto_errs++;
      $display("no stimulus lines were read from the vector file");
    end
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    waited = 0;
    while ((vec_next < n_vec || pend_q.size() != 0) && timeouts == 0) begin
      run_cycle();
      waited++;
      if (waited >= StimTimeout) begin
        timeouts++;
        $display("timeout: stimulus still pending after %0d cycles", waited);
      end
    end

    // drain with all outputs released
    stall_mask = '0;
    waited     = 0;
    while (sb_q.size() != 0 && timeouts == 0) begin
      run_cycle();
      waited++;
      if (waited >= DrainTimeout) begin
        timeouts++;
        $display("timeout: %0d flits still inside the router after drain", sb_q.size());
      end
    end

    if (timeouts == 0) begin
      // nothing more may come out of an empty router
      repeat (QuietCycles) run_cycle();
      assert (deliv_cnt == inj_cnt) else begin
        value_errs++;
        $display("[FAIL] test=delivered_count expected=%0d actual=%0d", inj_cnt, deliv_cnt);
      end
      assert (cred_cnt == inj_cnt) else begin
        value_errs++;
        $display("[FAIL] test=credit_count expected=%0d actual=%0d", inj_cnt, cred_cnt);
      end
      for (int p = 0; p < NumDirs; p++) begin
        for (int v = 0; v < NumVC; v++) begin
          assert (up_credit[p][v] == VCDepth) else begin
            value_errs++;
            $display("[FAIL] test=upstream_credit in=%0d vc=%0d expected=%0d actual=%0d",
                     p, v, VCDepth, up_credit[p][v]);
          end
        end
      end
    end

    $display("errors: value=%0d order=%0d protocol=%0d timeout=%0d flits=%0d",
             value_errs, order_errs, proto_errs, timeouts, inj_cnt);
    if (value_errs + order_errs + proto_errs + timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/vc_router_vectors.txt */
// columns (hex): cycle in_port in_vc dir payload stall_mask, cycle counts from reset release
// in_port 7 sends no flit and only updates the stall mask, cycle ffff ends the list
// lone flits into an idle router
0004 4 0 1 a001 00
000c 0 1 2 a002 00
// one input VC streaming to one output
0014 1 0 3 b001 00
0014 1 1 3 b002 00
0015 1 0 3 b003 00
0016 1 0 3 b004 00
0017 1 1 3 b005 00
// four inputs contend for the local output
0020 0 0 4 c000 00
0020 1 1 4 c001 00
0020 2 0 4 c002 00
0020 3 1 4 c003 00
0021 0 1 4 c010 00
0021 1 0 4 c011 00
0021 2 1 4 c012 00
0021 3 0 4 c013 00
// stall north and fill the input FIFOs behind it
0040 7 0 0 0000 01
0041 1 0 0 d001 01
0042 1 1 0 d002 01
0043 1 0 0 d003 01
0044 1 1 0 d004 01
0045 1 0 0 d005 01
0046 1 1 0 d006 01
0047 1 0 0 d007 01
0048 1 1 0 d008 01
0049 1 0 0 d009 01
004a 1 1 0 d00a 01
// east keeps flowing during the stall
0042 2 0 1 e001 01
0043 2 1 1 e002 01
// release north
0058 7 0 0 0000 00
// mixed traffic
0060 0 0 2 f001 00
0060 3 1 0 f002 00
0060 4 1 3 f003 00
0061 2 0 4 f004 00
0061 1 1 1 f005 00
0062 4 0 2 f006 00
0062 0 1 2 f007 00
0063 3 0 4 f008 00
ffff 0 0 0 0000 00

/* vc_router.f */
hdl/vc_router_pkg.sv
hdl/vc_input_port.sv
hdl/vc_sa_local.sv
hdl/vc_sa_global.sv
hdl/vc_out_credits.sv
hdl/vc_switch_traversal.sv
hdl/vc_router.sv
dv/vc_router_tb.sv

/* Bender.yml */
package:
  name: vc_router

sources:
  - files:
      - hdl/vc_router_pkg.sv
      - hdl/vc_input_port.sv
      - hdl/vc_sa_local.sv
      - hdl/vc_sa_global.sv
      - hdl/vc_out_credits.sv
      - hdl/vc_switch_traversal.sv
      - hdl/vc_router.sv
  - target: test
    files:
      - dv/vc_router_tb.sv
